/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_alu_top -f all.f
	out=$$(./obj_dir/Vtb_alu_top); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+.
alu_ops_pkg.sv
alu_data_pkg.sv
alu_addsub.sv
alu_logic_unit.sv
alu_shifter.sv
alu_writeback.sv
alu_top.sv
tb_alu_top.sv

/* alu_addsub.sv */
// combinational only; opcodes outside the nine add/subtract ops give a zero word and carry
`default_nettype none

`include "alu_params.svh"

module alu_addsub
	import alu_ops_pkg::*, alu_data_pkg::*;
(
	input alu_oper_e oper,
	input alu_word_u a,
	input alu_word_u b,
	input logic carry_in,
	output alu_unit_out_t out
);

	// sums one bit wider than the operands
	typedef logic [`ALU_BYTE_WIDTH:0] sum8_t;
	typedef logic [`ALU_PAIR_WIDTH:0] sum16_t;

	// lo b widened to a pair
	alu_pair_t b_zx;
	alu_pair_t b_sx;

	assign b_zx = {{`ALU_BYTE_WIDTH{1'b0}}, b.bytes.lo};
	// sign bit of lo b copied into the hi byte
	assign b_sx = {{`ALU_BYTE_WIDTH{b.bytes.lo[`ALU_BYTE_WIDTH-1]}}, b.bytes.lo};

	always_comb
	begin
		// hi byte stays zero for the byte ops
		out = '0;
		case (oper)
			alu_op_add:
				{out.carry, out.word.bytes.lo} = {1'b0, a.bytes.lo} + {1'b0, b.bytes.lo};
			alu_op_adc:
			begin
				// stored carry as the third addend
				{out.carry, out.word.bytes.lo} = {1'b0, a.bytes.lo} + {1'b0, b.bytes.lo}
					+ sum8_t'(carry_in);
			end
			alu_op_addpb:
				{out.carry, out.word.pair} = {1'b0, a.pair} + {1'b0, b_zx};
			alu_op_addp:
				{out.carry, out.word.pair} = {1'b0, a.pair} + {1'b0, b.pair};
			alu_op_addpsnx:
			begin
				// carry is bit 16 of the sign-extended sum
				{out.carry, out.word.pair} = {1'b0, a.pair} + {1'b0, b_sx};
			end
			alu_op_sub:
			begin
				// two's complement subtract, carry set means no borrow
				{out.carry, out.word.bytes.lo} = {1'b0, a.bytes.lo} + {1'b0, ~b.bytes.lo}
					+ sum8_t'(1);
			end
			alu_op_sbc:
			begin
				// stored carry replaces the +1
				{out.carry, out.word.bytes.lo} = {1'b0, a.bytes.lo} + {1'b0, ~b.bytes.lo}
					+ sum8_t'(carry_in);
			end
			alu_op_subpb:
				{out.carry, out.word.pair} = {1'b0, a.pair} + {1'b0, ~b_zx} + sum16_t'(1);
			alu_op_subp:
				{out.carry, out.word.pair} = {1'b0, a.pair} + {1'b0, ~b.pair} + sum16_t'(1);
			default:
				out = '0;
		endcase
	end

endmodule

`default_nettype wire

/* alu_data_pkg.sv */
// the word union overlays hi/lo bytes on the pair, so the pair is big-endian within the word
`default_nettype none

`include "alu_params.svh"

package alu_data_pkg;

	typedef logic [`ALU_BYTE_WIDTH-1:0] alu_byte_t;
	typedef logic [`ALU_PAIR_WIDTH-1:0] alu_pair_t;

	// hi byte sits in the upper half of the pair
	typedef struct packed
	{
		alu_byte_t hi;
		alu_byte_t lo;
	} alu_bytes_t;

	// byte ops use the bytes view, pair ops the pair view
	typedef union packed
	{
		alu_pair_t pair;
		alu_bytes_t bytes;
	} alu_word_u;

	// processor flags, carry above zero
	typedef struct packed
	{
		logic c;
		logic z;
	} alu_flags_t;

	// what the addsub and shift units hand to writeback
	typedef struct packed
	{
		alu_word_u word;
		logic carry;
	} alu_unit_out_t;

endpackage

`default_nettype wire

/* alu_logic_unit.sv */
// combinational; no carry output, writeback keeps the stored carry for every op here
`default_nettype none

module alu_logic_unit
	import alu_ops_pkg::*, alu_data_pkg::*;
(
	input alu_oper_e oper,
	input alu_word_u a,
	input alu_word_u b,
	output alu_word_u out
);

	always_comb
	begin
		// byte results leave the hi byte zero
		out = '0;
		case (oper)
			alu_op_and:
				out.bytes.lo = a.bytes.lo & b.bytes.lo;
			alu_op_orr:
				out.bytes.lo = a.bytes.lo | b.bytes.lo;
			alu_op_xor:
				out.bytes.lo = a.bytes.lo ^ b.bytes.lo;
			// complements only look at a
			alu_op_inv:
				out.bytes.lo = ~a.bytes.lo;
			alu_op_neg:
				out.bytes.lo = -a.bytes.lo;
			// pair forms over the whole word
			alu_op_invp:
				out.pair = ~a.pair;
			alu_op_negp:
				out.pair = -a.pair;
			default:
				out = '0;
		endcase
	end

endmodule

`default_nettype wire

/* alu_ops_pkg.sv */
// opcodes 23 to 31 are left undefined and are treated as keep-everything by the writeback stage
`default_nettype none

`include "alu_params.svh"

package alu_ops_pkg;

	// opcode encoding, order fixes the binary codes
	typedef enum logic [`ALU_OPER_WIDTH-1:0]
	{
		// byte and pair add
		alu_op_add,
		alu_op_adc,
		alu_op_addpb,
		alu_op_addp,
		alu_op_addpsnx,
		// byte and pair subtract
		alu_op_sub,
		alu_op_sbc,
		alu_op_subpb,
		alu_op_subp,
		// bitwise and complements
		alu_op_and,
		alu_op_orr,
		alu_op_xor,
		alu_op_inv,
		alu_op_invp,
		alu_op_neg,
		alu_op_negp,
		// pair shifts, amount in lo b
		alu_op_lslp,
		alu_op_lsrp,
		alu_op_asrp,
		// pair rotates, amount mod pair width
		alu_op_rolp,
		alu_op_rorp,
		// one-bit rotates through carry
		alu_op_rolcp,
		alu_op_rorcp
	} alu_oper_e;

	// how writeback picks result, carry and z
	typedef enum logic [2:0]
	{
		cat_arith8,
		cat_arith16,
		cat_logic8,
		cat_logic16,
		cat_shift16,
		cat_rotc16,
		cat_keep
	} alu_oper_cat_e;

endpackage

`default_nettype wire

/* alu_params.svh */
// pair width must be a power of two and exactly twice the byte width; rotate amount bits follow it
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// one register half
`define ALU_BYTE_WIDTH 8

// register pair, hi byte above lo byte
`define ALU_PAIR_WIDTH 16

// opcode field, room for 32 codes
`define ALU_OPER_WIDTH 5

// low bits of the shift byte used by pair rotates
// log2 of the pair width
`define ALU_ROT_AMT_WIDTH 4

`endif

/* alu_shifter.sv */
// no zero-amount test here, writeback keeps a and the flags when lo b is zero
`default_nettype none

`include "alu_params.svh"

module alu_shifter
	import alu_ops_pkg::*, alu_data_pkg::*;
(
	input alu_oper_e oper,
	input alu_word_u a,
	input alu_word_u b,
	input logic carry_in,
	output alu_unit_out_t out
);

	// rotate amount, mod pair width
	logic [`ALU_ROT_AMT_WIDTH-1:0] rot_amt;
	// pair written twice so a rotate is a plain part-select
	logic [2*`ALU_PAIR_WIDTH-1:0] doubled;

	assign rot_amt = b.bytes.lo[`ALU_ROT_AMT_WIDTH-1:0];
	assign doubled = {a.pair, a.pair};

	always_comb
	begin
		out = '0;
		case (oper)
			alu_op_lslp:
			begin
				// last bit shifted out of the top lands in carry
				{out.carry, out.word.pair} = {1'b0, a.pair} << b.bytes.lo;
			end
			alu_op_lsrp:
			begin
				// zero below the pair catches the last bit out of the bottom
				{out.word.pair, out.carry} = {a.pair, 1'b0} >> b.bytes.lo;
			end
			alu_op_asrp:
			begin
				// sign of a refills the top
				{out.word.pair, out.carry} = $signed({a.pair, 1'b0}) >>> b.bytes.lo;
			end
			alu_op_rolp:
			begin
				// window slides down from the upper copy
				out.word.pair = doubled[`ALU_PAIR_WIDTH - rot_amt +: `ALU_PAIR_WIDTH];
				out.carry = carry_in;
			end
			alu_op_rorp:
			begin
				out.word.pair = doubled[rot_amt +: `ALU_PAIR_WIDTH];
				// rotates keep the carry
				out.carry = carry_in;
			end
			alu_op_rolcp:
			begin
				// 17-bit rotate of {c, pair} by one, old c enters at bit 0
				{out.carry, out.word.pair} = {a.pair, carry_in};
			end
			alu_op_rorcp:
			begin
				// old c enters at the top, bit 0 leaves into carry
				{out.word.pair, out.carry} = {carry_in, a.pair};
			end
			default:
				out = '0;
		endcase
	end

endmodule

`default_nettype wire

/* alu_top.sv */
// one exec per cycle at most; carry ops read the flags left by the previous exec
`default_nettype none

module alu_top
	import alu_ops_pkg::*, alu_data_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic exec,
	input alu_oper_e oper,
	input alu_word_u a,
	input alu_word_u b,
	output alu_word_u result,
	output alu_flags_t flags,
	output logic done
);

	// unit results into writeback
	alu_unit_out_t addsub_out;
	alu_word_u logic_out;
	alu_unit_out_t shift_out;

	// adc and sbc take the registered carry
	alu_addsub u_addsub (
		.oper(oper),
		.a(a),
		.b(b),
		.carry_in(flags.c),
		.out(addsub_out)
	);

	alu_logic_unit u_logic (
		.oper(oper),
		.a(a),
		.b(b),
		.out(logic_out)
	);

	// rolcp and rorcp rotate through the same stored carry
	alu_shifter u_shifter (
		.oper(oper),
		.a(a),
		.b(b),
		.carry_in(flags.c),
		.out(shift_out)
	);

	alu_writeback u_writeback (
		.clk(clk),
		.rst(rst),
		.exec(exec),
		.oper(oper),
		.a(a),
		.b(b),
		.addsub_out(addsub_out),
		.logic_out(logic_out),
		.shift_out(shift_out),
		.result(result),
		.flags(flags),
		.done(done)
	);

endmodule

`default_nettype wire

/* alu_writeback.sv */
// result and flags load only on exec; done is a one-cycle pulse after each exec, no stall
`default_nettype none

module alu_writeback
	import alu_ops_pkg::*, alu_data_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic exec,
	input alu_oper_e oper,
	input alu_word_u a,
	input alu_word_u b,
	input alu_unit_out_t addsub_out,
	input alu_word_u logic_out,
	input alu_unit_out_t shift_out,
	output alu_word_u result,
	output alu_flags_t flags,
	output logic done
);

	alu_oper_cat_e cat;
	alu_oper_cat_e cat_eff;
	logic amt_zero;
	alu_word_u next_result;
	alu_flags_t next_flags;

	// opcode to category
	always_comb
	begin
		case (oper)
			alu_op_add, alu_op_adc, alu_op_sub, alu_op_sbc:
				cat = cat_arith8;
			alu_op_addpb, alu_op_addp, alu_op_addpsnx, alu_op_subpb, alu_op_subp:
				cat = cat_arith16;
			alu_op_and, alu_op_orr, alu_op_xor, alu_op_inv, alu_op_neg:
				cat = cat_logic8;
			alu_op_invp, alu_op_negp:
				cat = cat_logic16;
			alu_op_lslp, alu_op_lsrp, alu_op_asrp, alu_op_rolp, alu_op_rorp:
				cat = cat_shift16;
			alu_op_rolcp, alu_op_rorcp:
				cat = cat_rotc16;
			// undefined codes 23..31
			default:
				cat = cat_keep;
		endcase
	end

	// shift or rotate by zero changes nothing at all
	assign amt_zero = (b.bytes.lo == '0);
	assign cat_eff = (cat == cat_shift16 && amt_zero) ? cat_keep : cat;

	// result and carry select
	always_comb
	begin
		next_result = a;
		next_flags = flags;
		case (cat_eff)
			cat_arith8, cat_arith16:
			begin
				next_result = addsub_out.word;
				next_flags.c = addsub_out.carry;
			end
			// logic ops keep carry
			cat_logic8, cat_logic16:
				next_result = logic_out;
			cat_shift16, cat_rotc16:
			begin
				next_result = shift_out.word;
				next_flags.c = shift_out.carry;
			end
			default:
				next_result = a;
		endcase

		// z by width of the op, held for keep
		case (cat_eff)
			cat_arith8, cat_logic8:
				next_flags.z = (next_result.bytes.lo == '0);
			cat_keep:
				next_flags.z = flags.z;
			default:
				next_flags.z = (next_result.pair == '0);
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result <= '0;
			flags <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= exec;
			// hold between execs
			if (exec)
			begin
				result <= next_result;
				flags <= next_flags;
			end
		end
	end

endmodule

`default_nettype wire

/* tb_alu_model.svh */
// testbench reference model; assumes 8-bit bytes and 16-bit pairs, step returns {c, z, result}
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// carry is any sum past 255, hi byte of the result zero
function automatic logic [16:0] byte_sum(input int unsigned s);
	return {s > 255, 8'h00, 8'(s % 256)};
endfunction

// carry is any sum past 65535
function automatic logic [16:0] pair_sum(input int unsigned s);
	return {s > 65535, 16'(s % 65536)};
endfunction

// one exec, given the flags stored by the exec before it
function automatic logic [17:0] model_step(input logic [4:0] op, input logic [15:0] a,
	input logic [15:0] b, input logic c_in, input logic z_in);
	int unsigned al;
	int unsigned bl;
	int unsigned pa;
	logic [15:0] r;
	logic c;
	logic z;
	al = 32'(a[7:0]);
	bl = 32'(b[7:0]);
	pa = 32'(a);
	// undefined code, or a shift by zero: nothing changes but the result
	if (op > alu_op_rorcp || (op inside {alu_op_lslp, alu_op_lsrp, alu_op_asrp,
		alu_op_rolp, alu_op_rorp} && bl == 0))
		return {c_in, z_in, a};
	r = a;
	c = c_in;
	case (op)
		alu_op_add: {c, r} = byte_sum(al + bl);
		alu_op_adc: {c, r} = byte_sum(al + bl + 32'(c_in));
		// a minus b as a plus 255 minus b plus one
		alu_op_sub: {c, r} = byte_sum(al + 256 - bl);
		alu_op_sbc: {c, r} = byte_sum(al + 255 - bl + 32'(c_in));
		alu_op_addpb: {c, r} = pair_sum(pa + bl);
		alu_op_addp: {c, r} = pair_sum(pa + 32'(b));
		// lo b of 128 and up counts as negative
		alu_op_addpsnx: {c, r} = pair_sum(pa + ((bl < 128) ? bl : bl + 32'hff00));
		alu_op_subpb: {c, r} = pair_sum(pa + 65536 - bl);
		alu_op_subp: {c, r} = pair_sum(pa + 65536 - 32'(b));
		// logic keeps c
		alu_op_and: r = {8'h00, a[7:0] & b[7:0]};
		alu_op_orr: r = {8'h00, a[7:0] | b[7:0]};
		alu_op_xor: r = {8'h00, a[7:0] ^ b[7:0]};
		alu_op_inv: r = {8'h00, ~a[7:0]};
		alu_op_neg: r = {8'h00, 8'(256 - al)};
		alu_op_invp: r = ~a;
		alu_op_negp: r = 16'(65536 - pa);
		// last bit pushed out lands in c, nothing left past 16
		alu_op_lslp: {c, r} = {(bl <= 16) ? a[4'(16 - bl)] : 1'b0, a << bl};
		alu_op_lsrp: {c, r} = {(bl <= 16) ? a[4'(bl - 1)] : 1'b0, a >> bl};
		alu_op_asrp: {c, r} = {(bl <= 16) ? a[4'(bl - 1)] : a[15], 16'($signed(a) >>> bl)};
		// plain rotates wrap at 16, c untouched
		alu_op_rolp: r = (a << (bl % 16)) | (a >> (16 - bl % 16));
		alu_op_rorp: r = (a >> (bl % 16)) | (a << (16 - bl % 16));
		// 17-bit ring of c and the pair
		alu_op_rolcp: {c, r} = {a[15], a[14:0], c_in};
		alu_op_rorcp: {c, r} = {a[0], c_in, a[15:1]};
		default: r = a;
	endcase
	// byte ops look at the lo byte only
	if (op inside {alu_op_add, alu_op_adc, alu_op_sub, alu_op_sbc, alu_op_and,
		alu_op_orr, alu_op_xor, alu_op_inv, alu_op_neg})
		z = (r[7:0] == 8'h00);
	else
		z = (r == 16'h0000);
	return {c, z, r};
endfunction

`endif

/* tb_alu_top.sv */
// one op per cycle checked each falling edge against the model and the first mismatch ends the run
`default_nettype none

module tb_alu_top
	import alu_ops_pkg::*, alu_data_pkg::*;
();

	localparam int num_cycles = 3000;
	localparam int unsigned seed = 32'h9ff1;

	logic clk;
	logic rst;
	logic exec;
	alu_oper_e oper;
	alu_word_u a;
	alu_word_u b;
	alu_word_u result;
	alu_flags_t flags;
	logic done;

	// what the outputs should show after the last rising edge
	logic [15:0] exp_result;
	logic exp_c;
	logic exp_z;
	logic exp_done;

	`include "tb_alu_model.svh"

	alu_top u_dut (
		.clk(clk),
		.rst(rst),
		.exec(exec),
		.oper(oper),
		.a(a),
		.b(b),
		.result(result),
		.flags(flags),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// whole-run limit
	initial
	begin
		#(4 * (num_cycles + 200));
		fail_now("run did not finish in time");
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_outputs();
		assert (done === exp_done)
		else
			fail_now($sformatf("mismatch at %0t: done dut=%b exp=%b", $time, done, exp_done));
		assert (result.pair === exp_result)
		else
			fail_now($sformatf("mismatch at %0t: result dut=%h exp=%h", $time, result.pair,
				exp_result));
		assert (flags.c === exp_c)
		else
			fail_now($sformatf("mismatch at %0t: flags.c dut=%b exp=%b", $time, flags.c, exp_c));
		assert (flags.z === exp_z)
		else
			fail_now($sformatf("mismatch at %0t: flags.z dut=%b exp=%b", $time, flags.z, exp_z));
	endtask

	// drive at the falling edge and check one cycle later against the model
	task automatic issue(input logic do_exec, input logic [4:0] code, input logic [15:0] av,
		input logic [15:0] bv);
		exec = do_exec;
		oper = alu_oper_e'(code);
		a.pair = av;
		b.pair = bv;
		exp_done = do_exec;
		if (do_exec)
			{exp_c, exp_z, exp_result} = model_step(code, av, bv, exp_c, exp_z);
		@(negedge clk);
		check_outputs();
	endtask

	// idle cycle with fresh operands so held outputs get tested
	task automatic issue_idle();
		issue(1'b0, 5'($urandom % 32), 16'($urandom), 16'($urandom));
	endtask

	task automatic issue_random();
		logic do_exec;
		logic [15:0] bv;
		do_exec = ($urandom % 4) != 0;
		bv = 16'($urandom);
		// zero shift amount now and then
		if ($urandom % 8 == 0)
			bv[7:0] = 8'h00;
		issue(do_exec, 5'($urandom % 32), 16'($urandom), bv);
	endtask

	initial
	begin
		rst = 1'b1;
		exec = 1'b0;
		oper = alu_op_add;
		a = '0;
		b = '0;
		exp_result = '0;
		exp_c = 1'b0;
		exp_z = 1'b0;
		exp_done = 1'b0;
		void'($urandom(seed));
		// five rising edges in reset and then on to a falling edge
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// reset values
		check_outputs();
		// back to back byte carry chain
		issue(1'b1, alu_op_add, 16'h12ff, 16'h3401);
		issue(1'b1, alu_op_adc, 16'h0010, 16'h0020);
		issue(1'b1, alu_op_sbc, 16'h0005, 16'h0007);
		issue(1'b1, alu_op_sbc, 16'h0005, 16'h0003);
		// negative lo b
		issue(1'b1, alu_op_addpsnx, 16'h1234, 16'h0080);
		issue(1'b1, alu_op_rolcp, 16'h8001, 16'h0000);
		issue(1'b1, alu_op_rorcp, 16'h8001, 16'h0000);
		// zero amount and then an undefined code
		issue(1'b1, alu_op_lslp, 16'h4321, 16'hff00);
		issue(1'b1, 5'd27, 16'h5555, 16'h0001);
		for (int i = 0; i < num_cycles; i++)
			issue_random();
		// idle tail with done low and outputs held
		repeat (5) issue_idle();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
